// ==== all.f ====
verilog/bp_pkg.sv
verilog/direction_table.sv
verilog/target_buffer.sv
verilog/fetch_pc_unit.sv
verilog/branch_resolve.sv
verilog/branch_predictor.sv
dv/branch_predictor_chk.sv
dv/tb_branch_predictor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the run output
sim: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_branch_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_branch_predictor
    import bp_pkg::*;
;

    localparam int    INDEX_BITS = 7;
    localparam int    DEPTH      = 1 << INDEX_BITS;
    localparam word_t RESET_PC   = 32'h0000_0040;
    localparam int    N_CMP      = 12;
    localparam int    N_RAND     = 400;
    localparam int    PH_RESET   = 10;
    localparam int    PH_FETCH   = 17;
    localparam int    PH_CMP     = 6 * (N_CMP + 4);
    localparam int    PH_DIRECT  = 16;
    localparam int    LIMIT      = 2 * (PH_RESET + PH_FETCH + PH_CMP + PH_DIRECT + N_RAND);
    // trained branch, its target, an alias of it and a jump site
    localparam word_t P_BR  = 32'h0000_0330;
    localparam word_t T_BR  = 32'h0000_0480;
    localparam word_t A_BR  = 32'h0000_0530;
    localparam word_t J_PC  = 32'h0000_0160;

    logic clk = 1'b0;
    logic rst_n;
    logic fetch_en;
    logic ex_valid;
    xfer_op_t ex_op;
    branch_funct3_t ex_cmpop;
    word_t ex_pc;
    word_t ex_next_pc;
    word_t ex_rs1;
    word_t ex_rs2;
    word_t ex_target;
    word_t pc;
    word_t pred_next_pc;
    word_t redirect_pc;
    logic pred_taken;
    logic mispredict;

    integer seed;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    branch_funct3_t cmp_list [6];
    word_t bnd_a [4];
    word_t bnd_b [4];

    // reference model state
    int ref_cnt [DEPTH];
    logic ref_valid [DEPTH];
    word_t ref_tag [DEPTH];
    word_t ref_target [DEPTH];
    word_t ref_pc;
    logic m_taken;
    word_t m_cpc;
    word_t m_pnext;
    int m_idx;

    branch_predictor #(
        .INDEX_BITS (INDEX_BITS),
        .RESET_PC   (RESET_PC)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_en     (fetch_en),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_cmpop     (ex_cmpop),
        .ex_pc        (ex_pc),
        .ex_next_pc   (ex_next_pc),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_target    (ex_target),
        .pc           (pc),
        .pred_next_pc (pred_next_pc),
        .redirect_pc  (redirect_pc),
        .pred_taken   (pred_taken),
        .mispredict   (mispredict)
    );

    always #2 clk = ~clk;

    // signed compare done as unsigned with the sign bits flipped
    function automatic logic ref_outcome(input branch_funct3_t c, input word_t a, input word_t b);
        case (c)
            beq:     return a == b;
            bne:     return a != b;
            blt:     return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
            bge:     return !((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
            bltu:    return a < b;
            bgeu:    return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t ref_correct_pc(input xfer_op_t op, input logic taken,
                                             input word_t epc, input word_t tgt);
        if (op == op_jal || (op == op_br && taken)) begin
            return tgt;
        end else if (op == op_jalr) begin
            return tgt & 32'hffff_fffe;
        end
        return epc + 32'd4;
    endfunction

    function automatic logic ref_pred_taken(input word_t p);
        int idx;
        idx = int'(p[INDEX_BITS+1:2]);
        return (ref_cnt[idx] >= 2) && ref_valid[idx] && (ref_tag[idx] == (p >> (INDEX_BITS + 2)));
    endfunction

    function automatic word_t ref_pred_next(input word_t p);
        if (ref_pred_taken(p)) begin
            return ref_target[int'(p[INDEX_BITS+1:2])];
        end
        return p + 32'd4;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED t=%0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED t=%0t %s: expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic drive(input logic fe, input logic v, input xfer_op_t op,
                         input branch_funct3_t cmp, input word_t epc, input word_t enext,
                         input word_t a, input word_t b, input word_t tgt);
        @(posedge clk);
        fetch_en   <= fe;
        ex_valid   <= v;
        ex_op      <= op;
        ex_cmpop   <= cmp;
        ex_pc      <= epc;
        ex_next_pc <= enext;
        ex_rs1     <= a;
        ex_rs2     <= b;
        ex_target  <= tgt;
    endtask

    task automatic idle(input logic fe, input int n);
        repeat (n) drive(fe, 1'b0, op_other, beq, '0, '0, '0, '0, '0);
    endtask

    // direct expectations on the fetch side, independent of the model
    task automatic expect_fetch(input word_t exp_pc, input logic exp_taken, input word_t exp_next);
        @(negedge clk);
        check_word("pc", pc, exp_pc);
        check_bit("pred_taken", pred_taken, exp_taken);
        check_word("pred_next_pc", pred_next_pc, exp_next);
    endtask

    // model steps at the edge with the inputs the DUT sees
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                ref_cnt[i]   = 1;
                ref_valid[i] = 1'b0;
            end
            ref_pc = RESET_PC;
        end else begin
            m_taken = ref_outcome(ex_cmpop, ex_rs1, ex_rs2);
            m_cpc   = ref_correct_pc(ex_op, m_taken, ex_pc, ex_target);
            m_pnext = ref_pred_next(ref_pc);
            m_idx   = int'(ex_pc[INDEX_BITS+1:2]);
            if (ex_valid && ex_next_pc != m_cpc) begin
                ref_pc = m_cpc;
            end else if (fetch_en) begin
                ref_pc = m_pnext;
            end
            if (ex_valid && ex_op == op_br) begin
                if (m_taken && ref_cnt[m_idx] < 3) begin
                    ref_cnt[m_idx]++;
                end else if (!m_taken && ref_cnt[m_idx] > 0) begin
                    ref_cnt[m_idx]--;
                end
            end
            if (ex_valid && ((ex_op == op_br && m_taken) || ex_op == op_jal || ex_op == op_jalr)) begin
                ref_valid[m_idx]  = 1'b1;
                ref_tag[m_idx]    = ex_pc >> (INDEX_BITS + 2);
                ref_target[m_idx] = m_cpc;
            end
        end
    end

    // compare every output mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            check_word("pc", pc, ref_pc);
            check_bit("pred_taken", pred_taken, ref_pred_taken(ref_pc));
            check_word("pred_next_pc", pred_next_pc, ref_pred_next(ref_pc));
            check_bit("mispredict", mispredict, ex_valid && (ex_next_pc != ref_correct_pc(
                      ex_op, ref_outcome(ex_cmpop, ex_rs1, ex_rs2), ex_pc, ex_target)));
            check_word("redirect_pc", redirect_pc, ref_correct_pc(
                       ex_op, ref_outcome(ex_cmpop, ex_rs1, ex_rs2), ex_pc, ex_target));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        word_t r;
        word_t r2;
        word_t epc;
        word_t tgt;
        word_t a;
        word_t b;
        cmp_list = '{beq, bne, blt, bge, bltu, bgeu};
        bnd_a = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        bnd_b = '{32'h0000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001};
        seed = 32'h995e_9d4d;
        rst_n = 1'b0;
        fetch_en = 1'b0;
        ex_valid = 1'b0;
        ex_op = op_other;
        ex_cmpop = beq;
        ex_pc = '0;
        ex_next_pc = '0;
        ex_rs1 = '0;
        ex_rs2 = '0;
        ex_target = '0;
        repeat (PH_RESET) @(posedge clk);
        rst_n <= 1'b1;
        expect_fetch(RESET_PC, 1'b0, RESET_PC + 32'd4);
        idle(1'b1, 12);
        idle(1'b0, 4);

        // branch conditions, boundaries first
        for (int c = 0; c < 6; c++) begin
            for (int k = 0; k < N_CMP + 4; k++) begin
                r = $random(seed);
                if (k < 4) begin
                    a = bnd_a[k];
                    b = bnd_b[k];
                end else begin
                    a = $random(seed);
                    b = (k % 5 == 0) ? a : $random(seed);
                end
                epc = r & 32'h0000_00fc;
                drive(1'b1, 1'b1, op_br, cmp_list[c], epc, epc + 32'd4, a, b, epc + 32'h100);
            end
        end

        // train P taken, jump back to it and look up
        drive(1'b0, 1'b1, op_br, beq, P_BR, P_BR + 32'd4, 32'd5, 32'd5, T_BR);
        drive(1'b0, 1'b1, op_br, beq, P_BR, P_BR + 32'd4, 32'd5, 32'd5, T_BR);
        drive(1'b0, 1'b1, op_jal, beq, J_PC, J_PC + 32'd4, '0, '0, P_BR);
        idle(1'b0, 1);
        expect_fetch(P_BR, 1'b1, T_BR);
        // same index, other tag
        drive(1'b0, 1'b1, op_jal, beq, J_PC, J_PC + 32'd4, '0, '0, A_BR);
        idle(1'b0, 1);
        expect_fetch(A_BR, 1'b0, A_BR + 32'd4);
        // untrain, then jalr with an odd target back to P
        drive(1'b0, 1'b1, op_br, bne, P_BR, T_BR, 32'd5, 32'd5, T_BR);
        drive(1'b0, 1'b1, op_br, bne, P_BR, T_BR, 32'd5, 32'd5, T_BR);
        drive(1'b0, 1'b1, op_jalr, beq, J_PC, J_PC + 32'd4, '0, '0, P_BR | 32'd1);
        idle(1'b0, 1);
        expect_fetch(P_BR, 1'b0, P_BR + 32'd4);
        drive(1'b0, 1'b1, op_other, beq, J_PC, T_BR, '0, '0, T_BR);
        idle(1'b0, 1);
        expect_fetch(J_PC + 32'd4, 1'b0, J_PC + 32'd8);

        // random mix over a small PC range, high bit for aliasing
        for (int i = 0; i < N_RAND; i++) begin
            r   = $random(seed);
            r2  = $random(seed);
            epc = (r2 & 32'h0000_00fc) | (r[7] ? 32'h0000_0200 : 32'h0000_0000);
            tgt = (r2 >> 12) & 32'h0000_03fd;
            a   = {r[20], 27'b0, r[15:12]};
            b   = {r[21], 27'b0, r[19:16]};
            drive(r[0], r[1], xfer_op_t'(r[3:2]), cmp_list[int'(r[6:4]) % 6], epc,
                  r[8] ? epc + 32'd4 : tgt, a, b, tgt);
        end
        idle(1'b0, 2);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_branch_predictor

`default_nettype wire

// ==== dv/branch_predictor_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predictor_chk
    import bp_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  mispredict,
    input logic  pred_taken,
    input logic  btb_hit,
    input logic  btb_write,
    input word_t pc,
    input word_t redirect_pc
);

    // set by the first target buffer write after reset
    logic trained;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trained <= 1'b0;
        end else if (btb_write) begin
            trained <= 1'b1;
        end
    end

    redirect_loads_pc: assert property (@(posedge clk) disable iff (!rst_n)
        mispredict |=> pc == $past(redirect_pc))
        else $error("pc did not take redirect_pc after a mispredict");

    taken_needs_hit: assert property (@(posedge clk) disable iff (!rst_n)
        pred_taken |-> btb_hit)
        else $error("pred_taken high without a target buffer hit");

    no_taken_untrained: assert property (@(posedge clk) disable iff (!rst_n)
        !trained |-> !pred_taken)
        else $error("pred_taken high before any target buffer write");

endmodule : branch_predictor_chk

bind branch_predictor branch_predictor_chk chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .mispredict  (mispredict),
    .pred_taken  (pred_taken),
    .btb_hit     (btb_hit),
    .btb_write   (btb_write),
    .pc          (pc),
    .redirect_pc (redirect_pc)
);

`default_nettype wire

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predictor
    import bp_pkg::*;
#(
    parameter int    INDEX_BITS = 7,
    parameter word_t RESET_PC   = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           fetch_en,
    input  logic           ex_valid,
    input  xfer_op_t       ex_op,
    input  branch_funct3_t ex_cmpop,
    input  word_t          ex_pc,
    input  word_t          ex_next_pc,
    input  word_t          ex_rs1,
    input  word_t          ex_rs2,
    input  word_t          ex_target,
    output word_t          pc,
    output word_t          pred_next_pc,
    output word_t          redirect_pc,
    output logic           pred_taken,
    output logic           mispredict
);

    logic  dir_taken;
    logic  btb_hit;
    word_t btb_target;

    // training path from execute
    logic  dir_update;
    logic  btb_write;
    logic  upd_taken;
    word_t upd_pc;
    word_t upd_target;

    direction_table #(
        .INDEX_BITS (INDEX_BITS)
    ) u_direction_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_pc     (pc),
        .dir_taken (dir_taken),
        .update    (dir_update),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken)
    );

    target_buffer #(
        .INDEX_BITS (INDEX_BITS)
    ) u_target_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_pc      (pc),
        .btb_hit    (btb_hit),
        .btb_target (btb_target),
        .write      (btb_write),
        .upd_pc     (upd_pc),
        .upd_target (upd_target)
    );

    fetch_pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_pc_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_en     (fetch_en),
        .dir_taken    (dir_taken),
        .btb_hit      (btb_hit),
        .btb_target   (btb_target),
        .mispredict   (mispredict),
        .redirect_pc  (redirect_pc),
        .pc           (pc),
        .pred_next_pc (pred_next_pc),
        .pred_taken   (pred_taken)
    );

    branch_resolve u_branch_resolve (
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_cmpop    (ex_cmpop),
        .ex_pc       (ex_pc),
        .ex_next_pc  (ex_next_pc),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_target   (ex_target),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc),
        .dir_update  (dir_update),
        .btb_write   (btb_write),
        .upd_taken   (upd_taken),
        .upd_pc      (upd_pc),
        .upd_target  (upd_target)
    );

endmodule : branch_predictor

`default_nettype wire

// ==== verilog/branch_resolve.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_resolve
    import bp_pkg::*;
(
    input  logic           ex_valid,
    input  xfer_op_t       ex_op,
    input  branch_funct3_t ex_cmpop,
    input  word_t          ex_pc,
    input  word_t          ex_next_pc,
    input  word_t          ex_rs1,
    input  word_t          ex_rs2,
    input  word_t          ex_target,
    output logic           mispredict,
    output word_t          redirect_pc,
    output logic           dir_update,
    output logic           btb_write,
    output logic           upd_taken,
    output word_t          upd_pc,
    output word_t          upd_target
);

    logic  br_en;
    logic  xfer_taken;
    word_t correct_pc;

    // branch condition on the two operands
    always_comb begin
        case (ex_cmpop)
            beq:     br_en = (ex_rs1 == ex_rs2);
            bne:     br_en = (ex_rs1 != ex_rs2);
            blt:     br_en = ($signed(ex_rs1) < $signed(ex_rs2));
            bge:     br_en = ($signed(ex_rs1) >= $signed(ex_rs2));
            bltu:    br_en = (ex_rs1 < ex_rs2);
            bgeu:    br_en = (ex_rs1 >= ex_rs2);
            default: br_en = 1'b0;
        endcase
    end

    // correct next PC per transfer kind
    always_comb begin
        correct_pc = ex_pc + INSTR_BYTES;
        case (ex_op)
            op_br: begin
                if (br_en) begin
                    correct_pc = ex_target;
                end
            end
            op_jal:  correct_pc = ex_target;
            // jalr target has its low bit forced to zero
            op_jalr: correct_pc = {ex_target[31:1], 1'b0};
            default: correct_pc = ex_pc + INSTR_BYTES;
        endcase
    end

    assign xfer_taken = ((ex_op == op_br) && br_en)
                     || (ex_op == op_jal)
                     || (ex_op == op_jalr);

    assign mispredict  = ex_valid && (ex_next_pc != correct_pc);
    assign redirect_pc = correct_pc;

    // training strobes for both tables
    assign dir_update = ex_valid && (ex_op == op_br);
    assign btb_write  = ex_valid && xfer_taken;
    assign upd_taken  = br_en;
    assign upd_pc     = ex_pc;
    assign upd_target = correct_pc;

endmodule : branch_resolve

`default_nettype wire

// ==== verilog/fetch_pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_unit
    import bp_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fetch_en,
    input  logic  dir_taken,
    input  logic  btb_hit,
    input  word_t btb_target,
    input  logic  mispredict,
    input  word_t redirect_pc,
    output word_t pc,
    output word_t pred_next_pc,
    output logic  pred_taken
);

    word_t pc_plus4;

    assign pc_plus4 = pc + INSTR_BYTES;

    // taken only when the counter says so and a target is known
    assign pred_taken = dir_taken && btb_hit;

    always_comb begin
        if (pred_taken) begin
            pred_next_pc = btb_target;
        end else begin
            pred_next_pc = pc_plus4;
        end
    end

    // redirect from execute wins over the fetch enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (mispredict) begin
            pc <= redirect_pc;
        end else if (fetch_en) begin
            pc <= pred_next_pc;
        end
    end

endmodule : fetch_pc_unit

`default_nettype wire

// ==== verilog/target_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module target_buffer
    import bp_pkg::*;
#(
    parameter int INDEX_BITS = 7
) (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t rd_pc,
    output logic  btb_hit,
    output word_t btb_target,
    input  logic  write,
    input  word_t upd_pc,
    input  word_t upd_target
);

    localparam int DEPTH    = 1 << INDEX_BITS;
    // PC bits above the index and the byte offset
    localparam int TAG_BITS = 32 - INDEX_BITS - 2;

    logic [DEPTH-1:0]      valid;
    logic [TAG_BITS-1:0]   tags    [DEPTH];
    word_t                 targets [DEPTH];

    logic [INDEX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0]   rd_tag;
    logic [INDEX_BITS-1:0] upd_idx;
    logic [TAG_BITS-1:0]   upd_tag;

    assign rd_idx  = rd_pc[INDEX_BITS+1:2];
    assign rd_tag  = rd_pc[31:INDEX_BITS+2];
    assign upd_idx = upd_pc[INDEX_BITS+1:2];
    assign upd_tag = upd_pc[31:INDEX_BITS+2];

    // hit needs a valid entry and a matching tag
    assign btb_hit    = valid[rd_idx] && (tags[rd_idx] == rd_tag);
    assign btb_target = targets[rd_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (write) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (write) begin
            tags[upd_idx]    <= upd_tag;
            targets[upd_idx] <= upd_target;
        end
    end

endmodule : target_buffer

`default_nettype wire

// ==== verilog/direction_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module direction_table
    import bp_pkg::*;
#(
    parameter int INDEX_BITS = 7
) (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t rd_pc,
    output logic  dir_taken,
    input  logic  update,
    input  word_t upd_pc,
    input  logic  upd_taken
);

    localparam int DEPTH = 1 << INDEX_BITS;

    counter_t                counters [DEPTH];
    logic [INDEX_BITS-1:0]   rd_idx;
    logic [INDEX_BITS-1:0]   upd_idx;
    counter_t                rd_state;
    counter_t                upd_state;
    counter_t                next_state;

    // index skips the two byte-offset bits
    assign rd_idx  = rd_pc[INDEX_BITS+1:2];
    assign upd_idx = upd_pc[INDEX_BITS+1:2];

    assign rd_state  = counters[rd_idx];
    assign upd_state = counters[upd_idx];

    assign dir_taken = (rd_state == weak_taken) || (rd_state == strong_taken);

    // step one state toward the outcome, saturate at the ends
    always_comb begin
        case (upd_state)
            strong_not_taken: next_state = upd_taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   next_state = upd_taken ? weak_taken     : strong_not_taken;
            weak_taken:       next_state = upd_taken ? strong_taken   : weak_not_taken;
            strong_taken:     next_state = upd_taken ? strong_taken   : weak_taken;
            default:          next_state = weak_not_taken;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                counters[i] <= weak_not_taken;
            end
        end else if (update) begin
            counters[upd_idx] <= next_state;
        end
    end

endmodule : direction_table

`default_nettype wire

// ==== verilog/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // machine word for PCs, operands and targets
    typedef logic [31:0] word_t;

    // fetch step between sequential instructions
    localparam word_t INSTR_BYTES = 32'd4;

    // two-bit saturating counter states, ordered toward taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_t;

    // kind of control transfer seen in execute
    typedef enum logic [1:0] {
        op_other = 2'b00,
        op_br    = 2'b01,
        op_jal   = 2'b10,
        op_jalr  = 2'b11
    } xfer_op_t;

    // branch condition, RV32I funct3 encodings
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

endpackage : bp_pkg

`default_nettype wire
